//--- spi_master.f
logic/spi_cfg_pkg.sv
logic/spi_ctrl_pkg.sv
logic/spi_sck_gen.sv
logic/spi_gap_timer.sv
logic/spi_frame_ctrl.sv
logic/spi_master.sv
bench/spi_master_tb.sv

//--- bench/spi_master_tb.sv
`timescale 1ns/1ps

module spi_master_tb;
    import spi_cfg_pkg::*;

    localparam int FRAMES        = 14;                  // frames run by all tests together
    localparam int FRAME_MAX_CYC = 3 * 256 + 2 * 32 * 64; // all delays at max, slowest 32 bit word
    localparam int MARGIN_CYC    = 400;                 // setup and idle waits per frame

    logic      GCLK;
    logic      NRST;
    logic      start_i;
    spi_mode_e spi_mode_i;
    sck_div_e  sck_speed_i;
    word_len_e word_len_i;
    gap_t      ifg_i;
    gap_t      cs_sck_i;
    gap_t      sck_cs_i;
    spi_word_t mosi_data_i;
    logic      miso_i;
    logic      busy_o;
    spi_word_t miso_data_o;
    logic      mosi_o;
    logic      sclk_o;
    logic      cs_o;

    int        errors;
    int        n_frames;     // cs falling edges seen
    int        n_edges;      // sck edges in the current frame
    int        lead_cyc;     // cs fall to first sck edge
    int        half_cyc;
    int        half_min;
    int        half_max;
    int        cs_high_cyc;  // cs high time before the current frame
    int        bit_idx;      // next slave bit to drive
    time       t_cs_fall;
    time       t_cs_rise;
    time       t_edge;
    logic      lead;
    logic      sck_at_rise;
    spi_word_t slave_tx;
    spi_word_t slave_rx;

    spi_master u_spi_master (.*);

    initial begin
        GCLK = 1'b0;
        forever #5 GCLK = ~GCLK;
    end

    initial begin
        #((10 + FRAMES * (FRAME_MAX_CYC + MARGIN_CYC)) * 10);
        $display("timeout: the frames did not finish in the expected time");
        $display("Done: errors found");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // slave model and frame monitor

    always @(negedge cs_o) begin
        t_cs_fall   = $time;
        cs_high_cyc = int'((t_cs_fall - t_cs_rise) / 10);
        n_frames++;
        n_edges  = 0;
        half_min = 1000;
        half_max = 0;
        slave_rx = '0;
        bit_idx  = len_bits(word_len_i) - 1;
        #1;
        if (!spi_mode_i[0]) begin
            miso_i = slave_tx[bit_idx]; // phase 0, first bit before any edge
            bit_idx--;
        end
    end

    always @(posedge cs_o) begin
        t_cs_rise   = $time;
        sck_at_rise = sclk_o;
    end

    always @(sclk_o) begin
        if (cs_o === 1'b0) begin
            if (n_edges == 0) begin
                lead_cyc = int'(($time - t_cs_fall) / 10);
            end else begin
                half_cyc = int'(($time - t_edge) / 10);
                half_min = (half_cyc < half_min) ? half_cyc : half_min;
                half_max = (half_cyc > half_max) ? half_cyc : half_max;
            end
            t_edge = $time;
            n_edges++;
            lead = (sclk_o != spi_mode_i[1]); // sck left its idle level
            #1;
            if (lead != spi_mode_i[0]) begin
                slave_rx = {slave_rx[DATA_W-2:0], mosi_o};
            end else if (bit_idx >= 0) begin
                miso_i = slave_tx[bit_idx];
                bit_idx--;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks and helpers

    task automatic check_word(input spi_word_t got, input spi_word_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic int len_bits(input word_len_e len);
        case (len)
            LEN16:   return 16;
            LEN8:    return 8;
            LEN4:    return 4;
            default: return 32;
        endcase
    endfunction

    // GCLK cycles per sck half period
    function automatic int half_cycles(input sck_div_e speed);
        case (speed)
            DIV64:   return 32;
            DIV32:   return 16;
            DIV16:   return 8;
            default: return 64;
        endcase
    endfunction

    task automatic run_frame(input spi_mode_e mode, input sck_div_e speed, input word_len_e len,
                             input gap_t ifg, input gap_t cs_sck, input gap_t sck_cs,
                             input logic poke);
        spi_word_t tx;
        spi_word_t mask;
        int        bits;
        bits = len_bits(len);
        mask = (bits == DATA_W) ? '1 : ((spi_word_t'(1) << bits) - 1'b1);
        tx   = $urandom;
        @(posedge GCLK);
        #1;
        spi_mode_i  = mode;
        sck_speed_i = speed;
        word_len_i  = len;
        ifg_i       = ifg;
        cs_sck_i    = cs_sck;
        sck_cs_i    = sck_cs;
        mosi_data_i = tx;
        slave_tx    = $urandom;
        start_i     = 1'b1;
        wait (busy_o === 1'b1);
        @(posedge GCLK);
        #1;
        start_i = 1'b0;
        if (poke) begin
            repeat (20) @(posedge GCLK);
            #1;
            mosi_data_i = ~tx;
            start_i     = 1'b1; // second request while busy
            @(posedge GCLK);
            #1;
            start_i = 1'b0;
        end
        wait (busy_o === 1'b0);
        @(posedge GCLK);
        #1;
        check_word(slave_rx, tx & mask, "word seen by the slave");
        check_word(miso_data_o, slave_tx & mask, "miso_data_o");
        check_count(n_edges, 2 * bits, "sck edges in frame");
        check_count(half_min, half_cycles(speed), "shortest sck half period");
        check_count(half_max, half_cycles(speed), "longest sck half period");
        check_count(lead_cyc, int'(cs_sck) + 1, "cs fall to first sck edge");
        check_count(int'((t_cs_rise - t_edge) / 10), int'(sck_cs) + 1, "last sck edge to cs rise");
        check_bit(sck_at_rise, mode[1], "sck level at cs rise");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests

    task automatic test_reset();
        check_bit(cs_o, 1'b1, "cs_o after reset");
        check_bit(busy_o, 1'b0, "busy_o after reset");
        check_bit(sclk_o, spi_mode_i[1], "sclk_o after reset");
        check_bit(mosi_o, 1'b0, "mosi_o after reset");
        check_word(miso_data_o, '0, "miso_data_o after reset");
    endtask

    task automatic test_modes();
        for (int m = 0; m < 4; m++)
            run_frame(spi_mode_e'(m), DIV16, LEN32, 8'd2, 8'd3, 8'd2, 1'b0);
    endtask

    task automatic test_word_lengths();
        run_frame(MODE1, DIV32, LEN16, 8'd0, 8'd1, 8'd4, 1'b0);
        run_frame(MODE2, DIV16, LEN8, 8'd5, 8'd2, 8'd0, 1'b0);
        run_frame(MODE3, DIV64, LEN4, 8'd1, 8'd6, 8'd1, 1'b0);
    endtask

    task automatic test_speeds();
        for (int s = 0; s < 4; s++)
            run_frame(spi_mode_e'(3 - s), sck_div_e'(s), LEN8, 8'd1, 8'd2, 8'd3, 1'b0);
    endtask

    task automatic test_guard_times();
        run_frame(MODE0, DIV16, LEN8, 8'd20, 8'd255, 8'd9, 1'b0);
        run_frame(MODE1, DIV16, LEN8, 8'd20, 8'd1, 8'd255, 1'b0); // back to back
        check_bit(cs_high_cyc >= 20, 1'b1, "cs high time between frames");
    endtask

    task automatic test_ignored_start();
        int frames_before;
        frames_before = n_frames;
        run_frame(MODE3, DIV32, LEN32, 8'd4, 8'd2, 8'd2, 1'b1);
        repeat (300) @(posedge GCLK);
        check_count(n_frames, frames_before + 1, "frames after a start while busy");
        check_bit(busy_o, 1'b0, "busy_o after the ignored start");
    endtask

    initial begin
        void'($urandom(3));
        errors      = 0;
        n_frames    = 0;
        NRST        = 1'b0;
        start_i     = 1'b0;
        spi_mode_i  = MODE2;
        sck_speed_i = DIV16;
        word_len_i  = LEN32;
        ifg_i       = '0;
        cs_sck_i    = 8'd1;
        sck_cs_i    = '0;
        mosi_data_i = '0;
        miso_i      = 1'b0;
        slave_tx    = '0;
        t_cs_rise   = 0;
        t_edge      = 0;
        repeat (10) @(posedge GCLK);
        #1;
        NRST = 1'b1;
        test_reset();
        test_modes();
        test_word_lengths();
        test_speeds();
        test_guard_times();
        test_ignored_start();
        $display("frames %0d, errors %0d", n_frames, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- logic/spi_master.sv
`timescale 1ns/1ps

module spi_master (
    input  logic                   GCLK,
    input  logic                   NRST,
    input  logic                   start_i,
    input  spi_cfg_pkg::spi_mode_e spi_mode_i,
    input  spi_cfg_pkg::sck_div_e  sck_speed_i,
    input  spi_cfg_pkg::word_len_e word_len_i,
    input  spi_cfg_pkg::gap_t      ifg_i,
    input  spi_cfg_pkg::gap_t      cs_sck_i,
    input  spi_cfg_pkg::gap_t      sck_cs_i,
    input  spi_cfg_pkg::spi_word_t mosi_data_i,
    input  logic                   miso_i,
    output logic                   busy_o,
    output spi_cfg_pkg::spi_word_t miso_data_o,
    output logic                   mosi_o,
    output logic                   sclk_o,
    output logic                   cs_o
);
    import spi_ctrl_pkg::*;

    frame_state_e state;
    logic         gap_done;
    logic         lead_done;
    logic         trail_done;
    logic         lead_edge;
    logic         trail_edge;

    spi_frame_ctrl u_frame_ctrl (
        .GCLK         (GCLK),
        .NRST         (NRST),
        .start_i      (start_i),
        .spi_mode_i   (spi_mode_i),
        .word_len_i   (word_len_i),
        .mosi_data_i  (mosi_data_i),
        .miso_i       (miso_i),
        .gap_done_i   (gap_done),
        .lead_done_i  (lead_done),
        .trail_done_i (trail_done),
        .lead_edge_i  (lead_edge),
        .trail_edge_i (trail_edge),
        .state_o      (state),
        .busy_o       (busy_o),
        .cs_o         (cs_o),
        .mosi_o       (mosi_o),
        .miso_data_o  (miso_data_o)
    );

    spi_sck_gen u_sck_gen (
        .GCLK         (GCLK),
        .NRST         (NRST),
        .state_i      (state),
        .spi_mode_i   (spi_mode_i),
        .sck_speed_i  (sck_speed_i),
        .sclk_o       (sclk_o),
        .lead_edge_o  (lead_edge),
        .trail_edge_o (trail_edge)
    );

    spi_gap_timer u_gap_timer (
        .GCLK         (GCLK),
        .NRST         (NRST),
        .state_i      (state),
        .ifg_i        (ifg_i),
        .cs_sck_i     (cs_sck_i),
        .sck_cs_i     (sck_cs_i),
        .gap_done_o   (gap_done),
        .lead_done_o  (lead_done),
        .trail_done_o (trail_done)
    );

endmodule

//--- logic/spi_frame_ctrl.sv
`timescale 1ns/1ps

module spi_frame_ctrl (
    input  logic                       GCLK,
    input  logic                       NRST,
    input  logic                       start_i,
    input  spi_cfg_pkg::spi_mode_e     spi_mode_i,
    input  spi_cfg_pkg::word_len_e     word_len_i,
    input  spi_cfg_pkg::spi_word_t     mosi_data_i,
    input  logic                       miso_i,
    input  logic                       gap_done_i,
    input  logic                       lead_done_i,
    input  logic                       trail_done_i,
    input  logic                       lead_edge_i,
    input  logic                       trail_edge_i,
    output spi_ctrl_pkg::frame_state_e state_o,
    output logic                       busy_o,
    output logic                       cs_o,
    output logic                       mosi_o,
    output spi_cfg_pkg::spi_word_t     miso_data_o
);
    import spi_cfg_pkg::*;
    import spi_ctrl_pkg::*;

    logic                 start_q;
    logic                 start_edge;
    logic                 cpha;
    logic                 shift_edge;   // master drives the next bit
    logic                 sample_edge;  // master takes miso
    logic                 load_tx;
    logic                 frame_go;     // GAP to LEAD
    logic                 last_edge;
    logic [4:0]           tx_align;
    logic [BIT_CNT_W-1:0] last_cnt;
    logic [BIT_CNT_W-1:0] edge_cnt;
    spi_word_t            tx_sreg;
    spi_word_t            rx_sreg;

    ////////////////////////////////////////////////////////////////////////////
    // start edge and mode decode

    always_ff @(posedge GCLK) begin
        if (!NRST)
            start_q <= 1'b0;
        else
            start_q <= start_i;
    end

    assign start_edge  = start_i & ~start_q;
    assign cpha        = spi_mode_i[0];
    assign shift_edge  = cpha ? lead_edge_i : trail_edge_i;
    assign sample_edge = cpha ? trail_edge_i : lead_edge_i;

    // left alignment of the tx word and index of the final edge
    always_comb begin
        tx_align = 5'd0;
        last_cnt = 6'd63;
        case (word_len_i)
            LEN16: begin
                tx_align = 5'd16;
                last_cnt = 6'd31;
            end
            LEN8: begin
                tx_align = 5'd24;
                last_cnt = 6'd15;
            end
            LEN4: begin
                tx_align = 5'd28;
                last_cnt = 6'd7;
            end
            default: begin
                tx_align = 5'd0;
                last_cnt = 6'd63;
            end
        endcase
    end

    assign load_tx   = (state_o == IDLE) && start_edge;
    assign frame_go  = (state_o == GAP) && gap_done_i;
    assign last_edge = trail_edge_i && (edge_cnt == last_cnt);

    ////////////////////////////////////////////////////////////////////////////
    // frame FSM

    always_ff @(posedge GCLK) begin
        if (!NRST) begin
            state_o     <= IDLE;
            busy_o      <= 1'b0;
            cs_o        <= 1'b1;
            mosi_o      <= 1'b0;
            miso_data_o <= '0;
            edge_cnt    <= '0;
        end else begin
            case (state_o)
                IDLE: begin
                    if (start_edge)
                        state_o <= GAP;
                end
                GAP: begin
                    if (gap_done_i) begin
                        state_o  <= LEAD;
                        cs_o     <= 1'b0;
                        busy_o   <= 1'b1;
                        edge_cnt <= '0;
                        if (!cpha)
                            mosi_o <= tx_sreg[DATA_W-1]; // first bit ahead of sck
                    end
                end
                LEAD: begin
                    if (lead_done_i)
                        state_o <= SHIFT;
                end
                SHIFT: begin
                    if (lead_edge_i || trail_edge_i)
                        edge_cnt <= edge_cnt + 1'b1;
                    if (shift_edge)
                        mosi_o <= tx_sreg[DATA_W-1];
                    if (last_edge)
                        state_o <= TRAIL;
                end
                TRAIL: begin
                    if (trail_done_i) begin
                        state_o     <= IDLE;
                        cs_o        <= 1'b1;
                        busy_o      <= 1'b0;
                        mosi_o      <= 1'b0;
                        miso_data_o <= rx_sreg; // upper bits already zero
                    end
                end
                default: state_o <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // shift registers

    always_ff @(posedge GCLK) begin
        if (load_tx)
            tx_sreg <= mosi_data_i << tx_align;
        else if ((frame_go && !cpha) || ((state_o == SHIFT) && shift_edge))
            tx_sreg <= tx_sreg << 1;

        if (frame_go)
            rx_sreg <= '0;
        else if ((state_o == SHIFT) && sample_edge)
            rx_sreg <= {rx_sreg[DATA_W-2:0], miso_i}; // msb first
    end

endmodule

//--- logic/spi_gap_timer.sv
`timescale 1ns/1ps

module spi_gap_timer (
    input  logic                      GCLK,
    input  logic                      NRST,
    input  spi_ctrl_pkg::frame_state_e state_i,
    input  spi_cfg_pkg::gap_t         ifg_i,
    input  spi_cfg_pkg::gap_t         cs_sck_i,
    input  spi_cfg_pkg::gap_t         sck_cs_i,
    output logic                      gap_done_o,
    output logic                      lead_done_o,
    output logic                      trail_done_o
);
    import spi_cfg_pkg::*;
    import spi_ctrl_pkg::*;

    gap_t gap_cnt;    // cycles since the last frame ended
    gap_t guard_cnt;  // cycles since entering LEAD or TRAIL
    gap_t guard_lim;
    logic gap_wait;
    logic guard_hit;

    assign gap_wait = (state_i == IDLE) || (state_i == GAP);

    ////////////////////////////////////////////////////////////////////////////
    // interframe gap

    always_ff @(posedge GCLK) begin
        if (!NRST) begin
            gap_cnt <= '0;
        end else if (gap_wait) begin
            if (gap_cnt < ifg_i)
                gap_cnt <= gap_cnt + 1'b1; // saturates at the gap
        end else begin
            gap_cnt <= '0;
        end
    end

    assign gap_done_o = gap_wait && (gap_cnt >= ifg_i);

    ////////////////////////////////////////////////////////////////////////////
    // cs to sck and sck to cs guard delays

    // LEAD fires a cycle earlier since SHIFT adds one cycle before the first edge
    always_comb begin
        if (state_i == LEAD)
            guard_lim = (cs_sck_i == '0) ? '0 : cs_sck_i - 1'b1;
        else
            guard_lim = sck_cs_i;
    end

    always_ff @(posedge GCLK) begin
        if (!NRST)
            guard_cnt <= '0;
        else if ((state_i == LEAD) || (state_i == TRAIL))
            guard_cnt <= guard_cnt + 1'b1;
        else
            guard_cnt <= '0;
    end

    assign guard_hit    = (guard_cnt == guard_lim);
    assign lead_done_o  = (state_i == LEAD) && guard_hit;
    assign trail_done_o = (state_i == TRAIL) && guard_hit;

endmodule

//--- logic/spi_sck_gen.sv
`timescale 1ns/1ps

module spi_sck_gen (
    input  logic                      GCLK,
    input  logic                      NRST,
    input  spi_ctrl_pkg::frame_state_e state_i,
    input  spi_cfg_pkg::spi_mode_e    spi_mode_i,
    input  spi_cfg_pkg::sck_div_e     sck_speed_i,
    output logic                      sclk_o,
    output logic                      lead_edge_o,
    output logic                      trail_edge_o
);
    import spi_cfg_pkg::*;
    import spi_ctrl_pkg::*;

    logic                  cpol;     // idle level of sck
    logic [HALF_CNT_W-1:0] div_lim;  // last count of a half period
    logic [HALF_CNT_W-1:0] half_cnt;
    logic                  sck_edge;

    assign cpol = spi_mode_i[1];

    ////////////////////////////////////////////////////////////////////////////
    // speed select

    always_comb begin
        div_lim = 6'd63;
        case (sck_speed_i)
            DIV64:   div_lim = 6'd31;
            DIV32:   div_lim = 6'd15;
            DIV16:   div_lim = 6'd7;
            default: div_lim = 6'd63; // 1/128
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // edge strobes, high in the cycle that ends with the sck toggle

    assign sck_edge     = (state_i == SHIFT) && (half_cnt >= div_lim);
    assign lead_edge_o  = sck_edge && (sclk_o == cpol);   // leaving idle level
    assign trail_edge_o = sck_edge && (sclk_o != cpol);   // back to idle level

    ////////////////////////////////////////////////////////////////////////////
    // divider

    always_ff @(posedge GCLK) begin
        if (!NRST) begin
            half_cnt <= '0;
            sclk_o   <= cpol;
        end else if (state_i != SHIFT) begin
            // preloaded so the first edge comes one cycle into SHIFT
            half_cnt <= div_lim;
            sclk_o   <= cpol;
        end else if (sck_edge) begin
            half_cnt <= '0;
            sclk_o   <= ~sclk_o;
        end else begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

endmodule

//--- logic/spi_ctrl_pkg.sv
package spi_ctrl_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // frame sequencing

    typedef enum logic [2:0] {
        IDLE  = 3'd0, // waiting for a start edge
        GAP   = 3'd1, // interframe gap still running
        LEAD  = 3'd2, // cs low, before the first clock edge
        SHIFT = 3'd3, // clock running
        TRAIL = 3'd4  // after the last clock edge, cs still low
    } frame_state_e;

    // half period counter, covers the 1/128 divider
    localparam int HALF_CNT_W = 6;

    // edge counter, up to 64 edges per frame
    localparam int BIT_CNT_W = 6;

endpackage

//--- logic/spi_cfg_pkg.sv
package spi_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bus mode, upper bit is clock polarity and lower bit is clock phase

    typedef enum logic [1:0] {
        MODE0 = 2'b00, // idle low, sample on rising edge
        MODE1 = 2'b01, // idle low, sample on falling edge
        MODE2 = 2'b10, // idle high, sample on falling edge
        MODE3 = 2'b11  // idle high, sample on rising edge
    } spi_mode_e;

    // serial clock as a fraction of GCLK
    typedef enum logic [1:0] {
        DIV128 = 2'd0,
        DIV64  = 2'd1,
        DIV32  = 2'd2,
        DIV16  = 2'd3
    } sck_div_e;

    // bits per frame
    typedef enum logic [1:0] {
        LEN32 = 2'd0,
        LEN16 = 2'd1,
        LEN8  = 2'd2,
        LEN4  = 2'd3
    } word_len_e;

    localparam int DATA_W = 32;

    typedef logic [DATA_W-1:0] spi_word_t;
    typedef logic [7:0]        gap_t;      // delay in GCLK cycles

endpackage
